// ==== hdl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Fetch tag width, wraps around
`define FETCH_TAG_BITS 4

// Cache geometry, one 32-bit word per line
`define ICACHE_INDEX_BITS 4
`define ICACHE_LINES (1 << `ICACHE_INDEX_BITS)

// Address tag kept per line (word address bits above the index)
`define ICACHE_TAG_BITS (30 - `ICACHE_INDEX_BITS)

// First PC fetched after reset
`define FETCH_RESET_PC 32'h0000_0000

// Byte step between sequential instructions
`define FETCH_PC_STEP 32'd4

`endif

// ==== hdl/cpu_pkg.sv ====
`include "fetch_cfg.svh"

package cpu_pkg;

	// Major opcode in instruction bits 31:28
	typedef enum logic [3:0] {
		OP_ALU       = 4'h0,
		OP_LOAD      = 4'h1,
		OP_STORE     = 4'h2,
		OP_JUMP      = 4'h3,
		OP_JUMP_COND = 4'h4,
		OP_NOP       = 4'h5
	} opcode_e;

	// Fetch controller states
	typedef enum logic {
		RUN         = 1'b0,
		WAIT_BRANCH = 1'b1
	} fetch_state_e;

	// Memory bus request, held until the ready pulse
	typedef struct packed {
		logic        req;
		logic [31:0] addr;
	} bus_req_t;

	// One item handed to the pipeline
	typedef struct packed {
		logic [`FETCH_TAG_BITS-1:0] tag;
		logic [31:0]                instr;
		logic [31:0]                pc;
	} fetch_out_t;

	// Branch outcome from the back end
	typedef struct packed {
		logic [`FETCH_TAG_BITS-1:0] tag;
		logic [31:0]                next_pc;
	} branch_resolve_t;

endpackage

// ==== hdl/icache.sv ====
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module icache (
	input  logic              i_clock,
	input  logic              i_reset,

	// Lookup side
	input  logic [31:0]       i_pc,
	input  logic              i_hold,
	output logic [31:0]       o_rdata,
	output logic              o_hit,

	// Memory bus
	output cpu_pkg::bus_req_t o_bus,
	input  logic              i_bus_ready,
	input  logic [31:0]       i_bus_rdata
);

	// Per line state
	logic [`ICACHE_LINES-1:0]    line_valid;
	logic [`ICACHE_TAG_BITS-1:0] line_tag [`ICACHE_LINES];
	logic [31:0]                 line_data [`ICACHE_LINES];

	// Address split of the lookup PC
	logic [`ICACHE_INDEX_BITS-1:0] pc_index;
	logic [`ICACHE_TAG_BITS-1:0]   pc_tag;

	// Address split of the word being filled
	logic [`ICACHE_INDEX_BITS-1:0] fill_index;
	logic [`ICACHE_TAG_BITS-1:0]   fill_tag;

	logic        req_q;
	logic [31:0] addr_q;
	logic        start_fill;
	logic        fill_done;

	assign pc_index = i_pc[`ICACHE_INDEX_BITS+1:2];
	assign pc_tag   = i_pc[31:`ICACHE_INDEX_BITS+2];

	assign fill_index = addr_q[`ICACHE_INDEX_BITS+1:2];
	assign fill_tag   = addr_q[31:`ICACHE_INDEX_BITS+2];

	// Combinational lookup
	assign o_rdata = line_data[pc_index];
	assign o_hit   = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);

	// Only one fill in flight, none started under hold
	assign start_fill = !req_q && !o_hit && !i_hold;
	assign fill_done  = req_q && i_bus_ready;

	assign o_bus.req  = req_q;
	assign o_bus.addr = addr_q;

	// Request level and valid bits
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			req_q <= 1'b0;
			line_valid <= '0;
		end else if (fill_done) begin
			req_q <= 1'b0;
			line_valid[fill_index] <= 1'b1;
		end else if (start_fill) begin
			req_q <= 1'b1;
		end
	end

	// Request address, captured word aligned
	always_ff @(posedge i_clock) begin
		if (start_fill) begin
			addr_q <= {i_pc[31:2], 2'b00};
		end
	end

	// Line write on the ready cycle
	always_ff @(posedge i_clock) begin
		if (fill_done) begin
			line_tag[fill_index]  <= fill_tag;
			line_data[fill_index] <= i_bus_rdata;
		end
	end

	// Held request keeps its address until ready
	a_req_stable: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(req_q && !i_bus_ready) |=> (req_q && $stable(addr_q))
	) else $error("icache: bus request dropped or address moved before ready");

	// Memory side must not answer an idle bus
	a_ready_with_req: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> req_q
	) else $error("icache: bus ready without a pending request");

endmodule

// ==== hdl/cpu_fetch.sv ====
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module cpu_fetch (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_stall,

	// Back end branch result
	input  cpu_pkg::branch_resolve_t i_resolve,

	// Pipeline output
	output cpu_pkg::fetch_out_t      o_out,

	// Cache side
	output logic [31:0]              o_pc,
	output logic                     o_cache_hold,
	input  logic [31:0]              i_cache_rdata,
	input  logic                     i_cache_hit
);

	cpu_pkg::fetch_state_e state_q;
	cpu_pkg::fetch_state_e state_d;

	logic [31:0] pc_q;
	logic [31:0] pc_d;

	cpu_pkg::fetch_out_t out_q;
	cpu_pkg::fetch_out_t out_d;

	// Branch detection from the opcode field only
	cpu_pkg::opcode_e opcode;
	logic             is_branch;
	logic             resolve_match;

	assign opcode    = cpu_pkg::opcode_e'(i_cache_rdata[31:28]);
	assign is_branch = (opcode == cpu_pkg::OP_JUMP) || (opcode == cpu_pkg::OP_JUMP_COND);

	assign resolve_match = (i_resolve.tag == out_q.tag);

	assign o_out        = out_q;
	assign o_pc         = pc_q;
	assign o_cache_hold = i_stall || (state_q == cpu_pkg::WAIT_BRANCH);

	always_comb begin
		state_d = state_q;
		pc_d    = pc_q;
		out_d   = out_q;

		// Stall freezes everything
		if (!i_stall) begin
			case (state_q)
				cpu_pkg::RUN: begin
					if (i_cache_hit) begin
						out_d.tag   = out_q.tag + 1'b1;
						out_d.instr = i_cache_rdata;
						out_d.pc    = pc_q;

						if (is_branch) begin
							// Hold the PC until the back end resolves
							state_d = cpu_pkg::WAIT_BRANCH;
						end else begin
							pc_d = pc_q + `FETCH_PC_STEP;
						end
					end
				end

				cpu_pkg::WAIT_BRANCH: begin
					// Only the resolve for our own branch counts
					if (resolve_match) begin
						pc_d    = i_resolve.next_pc;
						state_d = cpu_pkg::RUN;
					end
				end

				default: begin
					state_d = cpu_pkg::RUN;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= cpu_pkg::RUN;
			pc_q    <= `FETCH_RESET_PC;
			out_q   <= '0;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
			out_q   <= out_d;
		end
	end

	// PC parked while waiting on an unresolved branch
	a_pc_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(state_q == cpu_pkg::WAIT_BRANCH && (i_stall || !resolve_match)) |=> $stable(pc_q)
	) else $error("cpu_fetch: PC moved while waiting for branch resolve");

	// Tag sequence has no gaps outside reset
	a_tag_step: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(!$past(i_reset) && (out_q.tag != $past(out_q.tag)))
			|-> (out_q.tag == `FETCH_TAG_BITS'($past(out_q.tag) + 1'b1))
	) else $error("cpu_fetch: output tag did not step by one");

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_stall,

	// Back end
	input  cpu_pkg::branch_resolve_t i_resolve,
	output cpu_pkg::fetch_out_t      o_fetch,

	// Memory bus
	output cpu_pkg::bus_req_t        o_bus,
	input  logic                     i_bus_ready,
	input  logic [31:0]              i_bus_rdata
);

	// Fetch to cache
	logic [31:0] fetch_pc;
	logic        cache_hold;
	logic [31:0] cache_rdata;
	logic        cache_hit;

	cpu_fetch u_fetch (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_stall       (i_stall),
		.i_resolve     (i_resolve),
		.o_out         (o_fetch),
		.o_pc          (fetch_pc),
		.o_cache_hold  (cache_hold),
		.i_cache_rdata (cache_rdata),
		.i_cache_hit   (cache_hit)
	);

	icache u_icache (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_pc        (fetch_pc),
		.i_hold      (cache_hold),
		.o_rdata     (cache_rdata),
		.o_hit       (cache_hit),
		.o_bus       (o_bus),
		.i_bus_ready (i_bus_ready),
		.i_bus_rdata (i_bus_rdata)
	);

endmodule

// ==== tb/bus_memory_model.sv ====
`timescale 1ns/10ps

module bus_memory_model (
	input  logic              i_clock,
	input  logic              i_reset,

	// Bus from the DUT
	input  cpu_pkg::bus_req_t i_bus,
	output logic              o_ready,
	output logic [31:0]       o_rdata
);

	// Program storage, byte address bits 7:2 select the word
	logic [31:0] mem [64];

	// Requests accepted since time zero
	int req_count = 0;

	int seed = 94;
	int wait_left;
	logic busy;

	initial begin
		o_ready = 1'b0;
		o_rdata = '0;
		busy = 1'b0;
		wait_left = 0;
	end

	// Preload one word
	task automatic load_word(input logic [5:0] index, input logic [31:0] data);
		mem[index] = data;
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			busy <= 1'b0;
			wait_left <= 0;
		end else begin
			o_ready <= 1'b0;
			if (i_bus.req && !busy && !o_ready) begin
				// New request, answer after 1 to 4 cycles
				busy <= 1'b1;
				wait_left <= 1 + ({$random(seed)} % 4);
				req_count <= req_count + 1;
			end else if (busy) begin
				if (wait_left == 1) begin
					o_ready <= 1'b1;
					o_rdata <= mem[i_bus.addr[7:2]];
					busy <= 1'b0;
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

// ==== tb/tb_fetch_top.sv ====
`timescale 1ns/10ps
`include "fetch_cfg.svh"

module tb_fetch_top;

	localparam int CLOCK_PERIOD = 40;
	localparam int NUM_TESTS = 5;
	localparam int ITEM_TIMEOUT = 60;

	logic clock = 1'b0;
	logic reset;
	logic stall;
	cpu_pkg::branch_resolve_t resolve;
	cpu_pkg::fetch_out_t fetch_out;
	cpu_pkg::bus_req_t bus;
	logic bus_ready;
	logic [31:0] bus_rdata;

	int errors = 0;
	int seed = 94;

	// Reference model state
	logic [31:0] prog [64];
	logic [31:0] exp_pc;
	logic [`FETCH_TAG_BITS-1:0] exp_tag;

	// Items seen by the monitor, oldest first
	cpu_pkg::fetch_out_t items [$];
	logic [`FETCH_TAG_BITS-1:0] last_tag;

	// Address of every bus request, in issue order
	logic [31:0] req_addrs [$];
	logic last_req = 1'b0;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	fetch_top dut (
		.i_clock     (clock),
		.i_reset     (reset),
		.i_stall     (stall),
		.i_resolve   (resolve),
		.o_fetch     (fetch_out),
		.o_bus       (bus),
		.i_bus_ready (bus_ready),
		.i_bus_rdata (bus_rdata)
	);

	bus_memory_model u_mem (
		.i_clock (clock),
		.i_reset (reset),
		.i_bus   (bus),
		.o_ready (bus_ready),
		.o_rdata (bus_rdata)
	);

	// A new item shows up only as a tag change
	always @(negedge clock) begin
		if (reset) begin
			last_tag = fetch_out.tag;
		end else if (fetch_out.tag != last_tag) begin
			items.push_back(fetch_out);
			last_tag = fetch_out.tag;
		end
		if (bus.req && !last_req) begin
			req_addrs.push_back(bus.addr);
		end
		last_req = bus.req;
	end

	function automatic logic [31:0] make_word(input cpu_pkg::opcode_e op, input int index);
		logic [31:0] byte_addr;
		byte_addr = index * 4;
		return {op, 4'hA, byte_addr[23:0]};
	endfunction

	function automatic cpu_pkg::opcode_e plain_op(input int index);
		case (index % 4)
			0: return cpu_pkg::OP_ALU;
			1: return cpu_pkg::OP_LOAD;
			2: return cpu_pkg::OP_STORE;
			default: return cpu_pkg::OP_NOP;
		endcase
	endfunction

	function automatic logic is_branch_word(input logic [31:0] word);
		return (word[31:28] == cpu_pkg::OP_JUMP) || (word[31:28] == cpu_pkg::OP_JUMP_COND);
	endfunction

	task automatic build_linear();
		for (int i = 0; i < 64; i++) begin
			prog[6'(i)] = make_word(plain_op(i), i);
		end
	endtask

	task automatic write_program();
		for (int i = 0; i < 64; i++) begin
			u_mem.load_word(6'(i), prog[6'(i)]);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		stall <= 1'b0;
		resolve <= '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		items.delete();
		exp_tag = 1;
		exp_pc = `FETCH_RESET_PC;
	endtask

	task automatic check_reset_state();
		if (bus.req !== 1'b0) begin
			$display("FAIL at %0t: o_bus.req expected 0 got %b", $time, bus.req);
			errors++;
		end
		if (fetch_out.tag !== '0) begin
			$display("FAIL at %0t: o_fetch.tag expected 0 got %0d", $time, fetch_out.tag);
			errors++;
		end
		if (fetch_out.instr !== 32'd0) begin
			$display("FAIL at %0t: o_fetch.instr expected 0 got %h", $time, fetch_out.instr);
			errors++;
		end
		if (fetch_out.pc !== 32'd0) begin
			$display("FAIL at %0t: o_fetch.pc expected 0 got %h", $time, fetch_out.pc);
			errors++;
		end
	endtask

	task automatic next_item(output cpu_pkg::fetch_out_t item, output bit found);
		int waited;
		waited = 0;
		while (items.size() == 0 && waited < ITEM_TIMEOUT) begin
			@(negedge clock);
			waited = waited + 1;
		end
		found = (items.size() != 0);
		if (found) begin
			item = items.pop_front();
		end else begin
			item = '0;
			$display("Error at %0t: no new fetch item within %0d cycles", $time, ITEM_TIMEOUT);
			errors++;
		end
	endtask

	// Walk the reference PC and stop after a branch
	task automatic expect_items(input int count);
		cpu_pkg::fetch_out_t item;
		bit found;
		logic [31:0] exp_word;
		for (int n = 0; n < count; n++) begin
			next_item(item, found);
			if (!found) break;
			exp_word = prog[exp_pc[7:2]];
			if (item.tag !== exp_tag) begin
				$display("FAIL at %0t: o_fetch.tag expected %0d got %0d", $time, exp_tag, item.tag);
				errors++;
			end
			if (item.pc !== exp_pc) begin
				$display("FAIL at %0t: o_fetch.pc expected %h got %h", $time, exp_pc, item.pc);
				errors++;
			end
			if (item.instr !== exp_word) begin
				$display("FAIL at %0t: o_fetch.instr expected %h got %h",
					$time, exp_word, item.instr);
				errors++;
			end
			exp_tag = exp_tag + 1'b1;
			if (is_branch_word(exp_word)) break;
			exp_pc = exp_pc + 32'd4;
		end
	endtask

	// Resolve value stays on the port afterwards
	task automatic resolve_branch(input logic [`FETCH_TAG_BITS-1:0] tag, input logic [31:0] target);
		@(posedge clock);
		resolve.tag <= tag;
		resolve.next_pc <= target;
		exp_pc = target;
	endtask

	// Request count and consecutive word addresses from first_addr
	task automatic check_requests(input int base, input int addr_base, input int expected,
		input logic [31:0] first_addr);
		logic [31:0] exp_addr;
		if (u_mem.req_count - base != expected) begin
			$display("FAIL at %0t: bus request count expected %0d got %0d",
				$time, expected, u_mem.req_count - base);
			errors++;
		end
		for (int i = 0; i < expected && addr_base + i < req_addrs.size(); i++) begin
			exp_addr = first_addr + 32'(i * 4);
			if (req_addrs[addr_base + i] !== exp_addr) begin
				$display("FAIL at %0t: o_bus.addr expected %h got %h",
					$time, exp_addr, req_addrs[addr_base + i]);
				errors++;
			end
		end
	endtask

	task automatic test_reset();
		build_linear();
		write_program();
		apply_reset();
		check_reset_state();
		expect_items(6);
		// Reset again in the middle of a run
		apply_reset();
		check_reset_state();
		expect_items(4);
	endtask

	task automatic test_sequential();
		build_linear();
		write_program();
		apply_reset();
		// 20 items cover the tag wrap at 16
		expect_items(20);
	endtask

	task automatic test_stall();
		cpu_pkg::fetch_out_t held;
		logic stalled;
		int stretch;
		int collected;
		build_linear();
		write_program();
		apply_reset();
		stretch = 0;
		held = fetch_out;
		for (int cyc = 0; cyc < 150; cyc++) begin
			@(posedge clock);
			stalled = stall;
			if (stretch == 0) begin
				stall <= ~stall;
				stretch = 1 + ({$random(seed)} % 6);
			end else begin
				stretch = stretch - 1;
			end
			@(negedge clock);
			if (stalled && fetch_out !== held) begin
				$display("FAIL at %0t: o_fetch expected %h got %h", $time, held, fetch_out);
				errors++;
			end
			held = fetch_out;
		end
		@(posedge clock);
		stall <= 1'b0;
		collected = items.size();
		if (collected < 8) begin
			$display("Error at %0t: only %0d items fetched during the stall test", $time, collected);
			errors++;
		end
		expect_items(collected);
	endtask

	task automatic test_branch_wait();
		logic [`FETCH_TAG_BITS-1:0] branch_tag;
		build_linear();
		prog[4] = make_word(cpu_pkg::OP_JUMP, 4);
		write_program();
		apply_reset();
		expect_items(5);
		branch_tag = exp_tag - 1'b1;
		// Wrong tag must be ignored
		@(posedge clock);
		resolve.tag <= branch_tag + 1'b1;
		resolve.next_pc <= 32'd200;
		repeat (8) @(negedge clock);
		if (items.size() != 0) begin
			$display("Error at %0t: fetch went on before the branch was resolved", $time);
			errors++;
		end
		if (fetch_out.tag !== branch_tag) begin
			$display("FAIL at %0t: o_fetch.tag expected %0d got %0d", $time, branch_tag, fetch_out.tag);
			errors++;
		end
		resolve_branch(branch_tag, 32'd40);
		expect_items(6);
	endtask

	task automatic test_cache_hits();
		int base;
		int addr_base;
		build_linear();
		prog[5] = make_word(cpu_pkg::OP_JUMP_COND, 5);
		prog[36] = make_word(cpu_pkg::OP_JUMP, 36);
		write_program();
		apply_reset();
		base = u_mem.req_count;
		addr_base = req_addrs.size();
		expect_items(6);
		check_requests(base, addr_base, 6, 32'd0);
		// Loop back over lines already filled
		resolve_branch(exp_tag - 1'b1, 32'd0);
		base = u_mem.req_count;
		addr_base = req_addrs.size();
		expect_items(6);
		check_requests(base, addr_base, 0, 32'd0);
		// New region at 128 with five words up to the jump
		resolve_branch(exp_tag - 1'b1, 32'd128);
		base = u_mem.req_count;
		addr_base = req_addrs.size();
		expect_items(5);
		check_requests(base, addr_base, 5, 32'd128);
	endtask

	initial begin
		#(NUM_TESTS * 400 * CLOCK_PERIOD);
		$display("Error: watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		resolve = '0;
		test_reset();
		test_sequential();
		test_stall();
		test_branch_wait();
		test_cache_hits();
		$display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/icache.sv
hdl/cpu_fetch.sv
hdl/fetch_top.sv
tb/bus_memory_model.sv
tb/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

verilator --binary --timing --assert -f project.f --top-module tb_fetch_top \
	-Mdir obj_dir -o sim_fetch_top \
	&& ./obj_dir/sim_fetch_top > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "^Test OK$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
